/* logic/rv_pkg.sv */
package rv_pkg;

	// data and address width
	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [4:0]      reg_idx_t;

	// first fetch address after reset
	localparam word_t RESET_PC = 32'h8000_0000;

	// major opcodes, bits [6:0]
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	// the only accepted system encoding
	localparam word_t EBREAK_WORD = 32'h0010_0073;

	// funct3 values for the integer groups
	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SR   = 3'b101;
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;

	// funct3 values for jalr and branches
	localparam logic [2:0] F3_JALR = 3'b000;
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		// lui passes the immediate through
		ALU_PASS_B,
		ALU_NONE
	} alu_op_e;

	// decoder to execute
	typedef struct packed {
		word_t    pc;
		word_t    op_a;
		word_t    op_b;
		word_t    imm;
		alu_op_e  alu_op;
		logic     use_pc_a;
		logic     use_imm_b;
		logic     is_jal;
		logic     is_jalr;
		logic     is_branch;
		logic     branch_ne;
		reg_idx_t rd;
		logic     wen;
	} dec_t;

	// execute to register file and wb port
	typedef struct packed {
		logic     wen;
		reg_idx_t waddr;
		word_t    wdata;
	} wb_t;

	// execute to pc_counter
	typedef struct packed {
		logic  taken;
		word_t target;
	} redirect_t;

endpackage

/* logic/pc_counter.sv */
module pc_counter (
	input  logic              clk,
	input  logic              rst,
	input  rv_pkg::redirect_t redirect_i,
	input  logic              ebreak_i,
	output rv_pkg::word_t     pc_o,
	output logic              halt_o
);

	import rv_pkg::*;

	word_t pc_q;
	word_t pc_next;
	word_t pc_seq;
	logic  halted_q;

	// sequential successor
	assign pc_seq = pc_q + 32'd4;

	// hold on ebreak and after it, otherwise follow redirect
	always_comb begin
		if (halted_q || ebreak_i) begin
			pc_next = pc_q;
		end else if (redirect_i.taken) begin
			pc_next = redirect_i.target;
		end else begin
			pc_next = pc_seq;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			pc_q     <= RESET_PC;
			halted_q <= 1'b0;
		end else begin
			pc_q <= pc_next;
			// sticky until reset
			if (ebreak_i) begin
				halted_q <= 1'b1;
			end
		end
	end

	assign pc_o   = pc_q;
	assign halt_o = halted_q;

endmodule

/* logic/register_file.sv */
module register_file (
	input  logic             clk,
	input  logic             rst,
	input  rv_pkg::reg_idx_t raddr1_i,
	input  rv_pkg::reg_idx_t raddr2_i,
	input  rv_pkg::wb_t      wb_i,
	output rv_pkg::word_t    rdata1_o,
	output rv_pkg::word_t    rdata2_o
);

	import rv_pkg::*;

	// x1..x31, x0 has no storage
	word_t regs [1:31];

	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_i.wen && (wb_i.waddr != 5'd0)) begin
			// writes to x0 dropped here
			regs[wb_i.waddr] <= wb_i.wdata;
		end
	end

	// combinational reads, x0 reads zero
	always_comb begin
		if (raddr1_i == 5'd0) begin
			rdata1_o = '0;
		end else begin
			rdata1_o = regs[raddr1_i];
		end
	end

	always_comb begin
		if (raddr2_i == 5'd0) begin
			rdata2_o = '0;
		end else begin
			rdata2_o = regs[raddr2_i];
		end
	end

endmodule

/* logic/decoder.sv */
module decoder (
	input  rv_pkg::word_t    inst_i,
	input  rv_pkg::word_t    pc_i,
	input  rv_pkg::word_t    rdata1_i,
	input  rv_pkg::word_t    rdata2_i,
	output rv_pkg::reg_idx_t raddr1_o,
	output rv_pkg::reg_idx_t raddr2_o,
	output rv_pkg::dec_t     dec_o,
	output logic             invalid_o,
	output logic             ebreak_o
);

	import rv_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	reg_idx_t   rd;
	word_t      imm_i;
	word_t      imm_u;
	word_t      imm_j;
	word_t      imm_b;
	logic       valid;
	logic       ebreak;
	logic       f7_zero;
	logic       f7_alt;

	// funct3 to alu op, alt picks sub or sra
	function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
		alu_op_e op;
		case (f3)
			F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
			F3_SLL:  op = ALU_SLL;
			F3_SLT:  op = ALU_SLT;
			F3_SLTU: op = ALU_SLTU;
			F3_XOR:  op = ALU_XOR;
			F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
			F3_OR:   op = ALU_OR;
			default: op = ALU_AND;
		endcase
		return op;
	endfunction

	// field split
	assign opcode = inst_i[6:0];
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];
	assign rd     = inst_i[11:7];

	// sources always read, unused ones ignored downstream
	assign raddr1_o = inst_i[19:15];
	assign raddr2_o = inst_i[24:20];

	// immediates, sign from bit 31
	assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
	assign imm_u = {inst_i[31:12], 12'b0};
	assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
	assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

	// exact funct7 patterns for rv32 shifts and the OP group
	assign f7_zero = (funct7 == 7'b0000000);
	assign f7_alt  = (funct7 == 7'b0100000);

	always_comb begin
		valid  = 1'b0;
		ebreak = 1'b0;
		dec_o  = '0;
		dec_o.pc     = pc_i;
		dec_o.op_a   = rdata1_i;
		dec_o.op_b   = rdata2_i;
		dec_o.rd     = rd;
		dec_o.alu_op = ALU_NONE;
		case (opcode)
			OPC_LUI: begin
				valid           = 1'b1;
				dec_o.imm       = imm_u;
				dec_o.alu_op    = ALU_PASS_B;
				dec_o.use_imm_b = 1'b1;
				dec_o.wen       = 1'b1;
			end
			OPC_AUIPC: begin
				valid           = 1'b1;
				dec_o.imm       = imm_u;
				dec_o.alu_op    = ALU_ADD;
				dec_o.use_pc_a  = 1'b1;
				dec_o.use_imm_b = 1'b1;
				dec_o.wen       = 1'b1;
			end
			OPC_JAL: begin
				valid        = 1'b1;
				dec_o.imm    = imm_j;
				dec_o.is_jal = 1'b1;
				dec_o.wen    = 1'b1;
			end
			OPC_JALR: begin
				// target through the alu adder
				valid           = (funct3 == F3_JALR);
				dec_o.imm       = imm_i;
				dec_o.alu_op    = ALU_ADD;
				dec_o.use_imm_b = 1'b1;
				dec_o.is_jalr   = 1'b1;
				dec_o.wen       = 1'b1;
			end
			OPC_BRANCH: begin
				// beq and bne only
				valid           = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
				dec_o.imm       = imm_b;
				dec_o.is_branch = 1'b1;
				dec_o.branch_ne = (funct3 == F3_BNE);
			end
			OPC_OPIMM: begin
				case (funct3)
					F3_SLL:  valid = f7_zero;
					F3_SR:   valid = f7_zero || f7_alt;
					default: valid = 1'b1;
				endcase
				// no subi, bit 30 only matters for srai
				dec_o.imm       = imm_i;
				dec_o.alu_op    = alu_sel(funct3, (funct3 == F3_SR) && funct7[5]);
				dec_o.use_imm_b = 1'b1;
				dec_o.wen       = 1'b1;
			end
			OPC_OP: begin
				// alternate funct7 only for sub and sra
				valid        = f7_zero ||
					(f7_alt && ((funct3 == F3_ADD) || (funct3 == F3_SR)));
				dec_o.alu_op = alu_sel(funct3, funct7[5]);
				dec_o.wen    = 1'b1;
			end
			OPC_SYSTEM: begin
				// exact ebreak word, nothing else here
				ebreak = (inst_i == EBREAK_WORD);
				valid  = ebreak;
			end
			default: begin
				valid = 1'b0;
			end
		endcase
		// unsupported encoding acts as a nop
		if (!valid) begin
			dec_o.wen       = 1'b0;
			dec_o.is_jal    = 1'b0;
			dec_o.is_jalr   = 1'b0;
			dec_o.is_branch = 1'b0;
		end
	end

	assign invalid_o = ~valid;
	assign ebreak_o  = ebreak;

endmodule

/* logic/execute.sv */
module execute (
	input  rv_pkg::dec_t      dec_i,
	output rv_pkg::wb_t       wb_o,
	output rv_pkg::redirect_t redirect_o
);

	import rv_pkg::*;

	word_t alu_a;
	word_t alu_b;
	word_t alu_res;
	word_t link;
	word_t pc_imm;
	logic  equal;
	logic  branch_taken;

	// operand muxes
	assign alu_a = dec_i.use_pc_a ? dec_i.pc : dec_i.op_a;
	assign alu_b = dec_i.use_imm_b ? dec_i.imm : dec_i.op_b;

	always_comb begin
		case (dec_i.alu_op)
			ALU_ADD:    alu_res = alu_a + alu_b;
			ALU_SUB:    alu_res = alu_a - alu_b;
			// shift amount is the low five bits
			ALU_SLL:    alu_res = alu_a << alu_b[4:0];
			ALU_SRL:    alu_res = alu_a >> alu_b[4:0];
			ALU_SRA:    alu_res = $signed(alu_a) >>> alu_b[4:0];
			ALU_SLT: begin
				alu_res = {{(XLEN-1){1'b0}}, ($signed(alu_a) < $signed(alu_b))};
			end
			ALU_SLTU: begin
				alu_res = {{(XLEN-1){1'b0}}, (alu_a < alu_b)};
			end
			ALU_XOR:    alu_res = alu_a ^ alu_b;
			ALU_OR:     alu_res = alu_a | alu_b;
			ALU_AND:    alu_res = alu_a & alu_b;
			ALU_PASS_B: alu_res = alu_b;
			default:    alu_res = '0;
		endcase
	end

	// return address for jal and jalr
	assign link = dec_i.pc + 32'd4;

	// jal and branch target
	assign pc_imm = dec_i.pc + dec_i.imm;

	// branches compare the raw register values
	assign equal        = (dec_i.op_a == dec_i.op_b);
	assign branch_taken = dec_i.is_branch && (equal ^ dec_i.branch_ne);

	always_comb begin
		wb_o.wen   = dec_i.wen;
		wb_o.waddr = dec_i.rd;
		if (dec_i.is_jal || dec_i.is_jalr) begin
			wb_o.wdata = link;
		end else begin
			wb_o.wdata = alu_res;
		end
	end

	always_comb begin
		redirect_o.taken = dec_i.is_jal || dec_i.is_jalr || branch_taken;
		// jalr clears bit 0 of rs1 + imm
		if (dec_i.is_jalr) begin
			redirect_o.target = {alu_res[XLEN-1:1], 1'b0};
		end else begin
			redirect_o.target = pc_imm;
		end
	end

endmodule

/* logic/core_top.sv */
module core_top (
	input  logic          clk,
	input  logic          rst,
	input  rv_pkg::word_t inst_i,
	output rv_pkg::word_t pc_o,
	output rv_pkg::wb_t   wb_o,
	output logic          invalid_o,
	output logic          halt_o
);

	import rv_pkg::*;

	// regfile read side
	reg_idx_t  raddr1;
	reg_idx_t  raddr2;
	word_t     rdata1;
	word_t     rdata2;

	// decode to execute
	dec_t      dec;
	logic      ebreak;

	// execute to pc
	redirect_t redirect;

	pc_counter i_pc_counter (
		.clk        (clk),
		.rst        (rst),
		.redirect_i (redirect),
		.ebreak_i   (ebreak),
		.pc_o       (pc_o),
		.halt_o     (halt_o)
	);

	// write port fed straight from execute
	register_file i_register_file (
		.clk      (clk),
		.rst      (rst),
		.raddr1_i (raddr1),
		.raddr2_i (raddr2),
		.wb_i     (wb_o),
		.rdata1_o (rdata1),
		.rdata2_o (rdata2)
	);

	decoder i_decoder (
		.inst_i    (inst_i),
		.pc_i      (pc_o),
		.rdata1_i  (rdata1),
		.rdata2_i  (rdata2),
		.raddr1_o  (raddr1),
		.raddr2_o  (raddr2),
		.dec_o     (dec),
		.invalid_o (invalid_o),
		.ebreak_o  (ebreak)
	);

	execute i_execute (
		.dec_i      (dec),
		.wb_o       (wb_o),
		.redirect_o (redirect)
	);

endmodule

/* testbench/core_model.svh */
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

// architectural state of the reference core
word_t m_regs [32];
word_t m_pc;
logic  m_halted;

function automatic void reset_state();
	for (int i = 0; i < 32; i++) begin
		m_regs[i[4:0]] = '0;
	end
	m_pc     = RESET_PC;
	m_halted = 1'b0;
endfunction

// integer result for OP and OP-IMM, alt selects sub or sra
function automatic word_t alu_result(
	input logic [2:0] f3,
	input logic       alt,
	input word_t      x,
	input word_t      y
);
	word_t r;
	case (f3)
		3'd0:    r = alt ? x - y : x + y;
		3'd1:    r = x << y[4:0];
		3'd2:    r = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
		3'd3:    r = (x < y) ? 32'd1 : 32'd0;
		3'd4:    r = x ^ y;
		3'd5: begin
			// sra keeps the sign, srl fills zeros
			if (alt) begin
				r = $signed(x) >>> y[4:0];
			end else begin
				r = x >> y[4:0];
			end
		end
		3'd6:    r = x | y;
		default: r = x & y;
	endcase
	return r;
endfunction

// retire one instruction, return the expected write-back and invalid flag
function automatic void retire_inst(input word_t inst, output wb_t wb, output logic invalid);
	logic [2:0] f3;
	logic [6:0] f7;
	reg_idx_t   rd;
	word_t      a;
	word_t      b;
	word_t      imm_i;
	word_t      imm_j;
	word_t      imm_b;
	word_t      res;
	word_t      next;
	logic       ok;
	logic       wr;
	f3    = inst[14:12];
	f7    = inst[31:25];
	rd    = inst[11:7];
	a     = m_regs[inst[19:15]];
	b     = m_regs[inst[24:20]];
	imm_i = {{20{inst[31]}}, inst[31:20]};
	imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
	imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	res   = '0;
	ok    = 1'b1;
	wr    = 1'b0;
	next  = m_pc + 32'd4;
	case (inst[6:0])
		OPC_LUI: begin
			wr  = 1'b1;
			res = {inst[31:12], 12'h000};
		end
		OPC_AUIPC: begin
			wr  = 1'b1;
			res = m_pc + {inst[31:12], 12'h000};
		end
		OPC_JAL: begin
			wr   = 1'b1;
			res  = m_pc + 32'd4;
			next = m_pc + imm_j;
		end
		OPC_JALR: begin
			ok   = (f3 == 3'd0);
			wr   = 1'b1;
			res  = m_pc + 32'd4;
			next = (a + imm_i) & ~32'd1;
		end
		OPC_BRANCH: begin
			// beq on f3 0, bne on f3 1
			ok = (f3 == 3'd0) || (f3 == 3'd1);
			if ((a == b) != f3[0]) begin
				next = m_pc + imm_b;
			end
		end
		OPC_OPIMM: begin
			if (f3 == 3'd1) begin
				ok = (f7 == 7'h00);
			end else if (f3 == 3'd5) begin
				ok = (f7 == 7'h00) || (f7 == 7'h20);
			end
			wr  = 1'b1;
			res = alu_result(f3, (f3 == 3'd5) && f7[5], a, imm_i);
		end
		OPC_OP: begin
			ok  = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
			wr  = 1'b1;
			res = alu_result(f3, f7[5], a, b);
		end
		OPC_SYSTEM: begin
			// ebreak parks the pc and halts
			ok = (inst == EBREAK_WORD);
			if (ok) begin
				next     = m_pc;
				m_halted = 1'b1;
			end
		end
		default: begin
			ok = 1'b0;
		end
	endcase
	// anything unsupported falls through as a nop
	if (!ok) begin
		wr   = 1'b0;
		next = m_pc + 32'd4;
	end
	if (wr && (rd != 5'd0)) begin
		m_regs[rd] = res;
	end
	m_pc     = next;
	wb.wen   = wr;
	wb.waddr = rd;
	wb.wdata = res;
	invalid  = !ok;
endfunction

`endif

/* testbench/core_tb.sv */
module core_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import rv_pkg::*;

	localparam int          PROG_WORDS     = 256;
	localparam int          RESET_CYCLES   = 5;
	localparam int          HALT_CYCLES    = 5;
	localparam int          TIMEOUT_CYCLES = PROG_WORDS + 50;
	localparam logic [31:0] SEED           = 32'h400b6978;
	// addi x0, x0, 0
	localparam word_t       NOP_WORD       = 32'h0000_0013;

	logic  clk;
	logic  rst;
	word_t inst_i;
	word_t pc_o;
	wb_t   wb_o;
	logic  invalid_o;
	logic  halt_o;

	word_t imem [PROG_WORDS];

	// comparing process state
	logic  checking;
	logic  done;
	logic  timed_out;
	int    cycles     = 0;
	int    post_halt  = 0;
	int    wb_errs    = 0;
	int    word_errs  = 0;
	int    flag_errs  = 0;
	int    other_errs = 0;
	word_t cur_inst;
	wb_t   exp_wb;
	logic  exp_invalid;

	`include "core_model.svh"

	core_top i_dut (
		.clk       (clk),
		.rst       (rst),
		.inst_i    (inst_i),
		.pc_o      (pc_o),
		.wb_o      (wb_o),
		.invalid_o (invalid_o),
		.halt_o    (halt_o)
	);

	always #2 clk = ~clk;

	// word address relative to RESET_PC, zero word outside the program
	function automatic word_t fetch(input word_t pc);
		word_t off;
		word_t w;
		off = pc - RESET_PC;
		w   = '0;
		if ((off[1:0] == 2'b00) && (off[31:10] == '0)) begin
			w = imem[off[9:2]];
		end
		return w;
	endfunction

	// instruction port, nop while in reset
	always_comb begin
		if (!rst) begin
			inst_i = NOP_WORD;
		end else begin
			inst_i = fetch(pc_o);
		end
	end

	// x0..x15 only, so sources often hit earlier writes
	function automatic reg_idx_t rand_reg();
		word_t r;
		r = $urandom;
		return {1'b0, r[3:0]};
	endfunction

	function automatic word_t jal_word(input reg_idx_t rd, input word_t off);
		return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
	endfunction

	function automatic word_t branch_word(
		input logic [2:0] f3,
		input reg_idx_t   rs1,
		input reg_idx_t   rs2,
		input word_t      off
	);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
	endfunction

	// encodings outside the supported set
	function automatic word_t invalid_word(
		input word_t    r,
		input reg_idx_t rs1,
		input reg_idx_t rs2,
		input reg_idx_t rd
	);
		word_t w;
		case (r[2:0])
			3'd0:    w = {r[31:20], rs1, 3'b010, rd, 7'b0000011};
			3'd1:    w = {7'h00, rs2, rs1, 3'b010, 5'h00, 7'b0100011};
			3'd2:    w = {7'h00, rs2, rs1, 3'b100, 5'b01000, OPC_BRANCH};
			// mul style funct7 in the OP group
			3'd3:    w = {7'h01, rs2, rs1, r[14:12], rd, OPC_OP};
			// slli with shamt bit 5 set
			3'd4:    w = {7'h01, r[24:20], rs1, 3'b001, rd, OPC_OPIMM};
			// alternate funct7 on and
			3'd5:    w = {7'h20, rs2, rs1, 3'b111, rd, OPC_OP};
			default: w = 32'h0000_0073;
		endcase
		return w;
	endfunction

	task automatic gen_program();
		int         i;
		int         kind;
		int         left;
		int         k;
		word_t      r;
		word_t      off;
		reg_idx_t   rd;
		reg_idx_t   rs1;
		reg_idx_t   rs2;
		logic [2:0] f3;
		logic       alt;
		// slots some jump lands on, kept free of jalr
		logic       hit [PROG_WORDS];
		for (int j = 0; j < PROG_WORDS; j++) begin
			hit[j] = 1'b0;
		end
		i = 0;
		while (i < PROG_WORDS - 1) begin
			kind = $urandom % 16;
			r    = $urandom;
			rd   = rand_reg();
			rs1  = rand_reg();
			rs2  = rand_reg();
			f3   = r[14:12];
			alt  = r[30];
			// forward distance, never past the last word
			left = PROG_WORDS - 1 - i;
			k    = 1 + ($urandom % ((left < 4) ? left : 4));
			if (kind < 4) begin
				alt         = alt && ((f3 == 3'd0) || (f3 == 3'd5));
				imem[i[7:0]] = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_OP};
			end else if (kind < 9) begin
				// shifts carry a five bit shamt, bit 30 only for srai
				if ((f3 == 3'd1) || (f3 == 3'd5)) begin
					r[31:25] = {1'b0, alt && (f3 == 3'd5), 5'b0};
				end
				imem[i[7:0]] = {r[31:20], rs1, f3, rd, OPC_OPIMM};
			end else if (kind < 11) begin
				imem[i[7:0]] = {r[31:12], rd, kind[0] ? OPC_LUI : OPC_AUIPC};
			end else if (kind == 11) begin
				imem[i[7:0]] = jal_word(rd, 4 * k);
				hit[i + k]   = 1'b1;
			end else if (kind < 14) begin
				imem[i[7:0]] = branch_word({2'b00, alt}, rs1, rs2, 4 * k);
				hit[i + k]   = 1'b1;
			end else if ((kind == 14) && (left > 1) && !hit[i + 1]) begin
				// auipc gives the base, jalr lands forward, bit 0 set now and then
				if (rs1 == 5'd0) begin
					rs1 = 5'd1;
				end
				imem[i[7:0]] = {20'h00000, rs1, OPC_AUIPC};
				i            = i + 1;
				k            = 1 + ($urandom % ((left - 1 < 4) ? left - 1 : 4));
				off          = 4 * (k + 1) + r[0];
				imem[i[7:0]] = {off[11:0], rs1, 3'b000, rd, OPC_JALR};
				hit[i + k]   = 1'b1;
			end else begin
				imem[i[7:0]] = invalid_word(r, rs1, rs2, rd);
			end
			i = i + 1;
		end
		imem[PROG_WORDS-1] = EBREAK_WORD;
	endtask

	task automatic check_wb(input wb_t exp, input wb_t act);
		string exp_s;
		string act_s;
		if (act !== exp) begin
			wb_errs++;
			exp_s = $sformatf("wen=%0b waddr=%0d wdata=%h", exp.wen, exp.waddr, exp.wdata);
			act_s = $sformatf("wen=%0b waddr=%0d wdata=%h", act.wen, act.waddr, act.wdata);
			$display("ERROR %0t wb_o expected %s actual %s", $time, exp_s, act_s);
		end
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			word_errs++;
			$display("ERROR %0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			flag_errs++;
			$display("ERROR %0t %s expected %b actual %b", $time, name, exp, act);
		end
	endtask

	// mid cycle, so pc, decode and write-back have all settled
	always @(negedge clk) begin
		if (checking && !done && !timed_out) begin
			cycles++;
			check_word("pc_o", m_pc, pc_o);
			check_flag("halt_o", m_halted, halt_o);
			cur_inst = fetch(m_pc);
			retire_inst(cur_inst, exp_wb, exp_invalid);
			check_flag("invalid_o", exp_invalid, invalid_o);
			if (exp_wb.wen) begin
				check_wb(exp_wb, wb_o);
			end else begin
				check_flag("wb_o.wen", 1'b0, wb_o.wen);
			end
			// a few parked cycles after ebreak
			if (m_halted) begin
				post_halt++;
			end
			if (post_halt == HALT_CYCLES) begin
				done = 1'b1;
			end else if (cycles >= TIMEOUT_CYCLES) begin
				timed_out = 1'b1;
			end
		end
	end

	initial begin
		clk       = 1'b0;
		rst       = 1'b0;
		checking  = 1'b0;
		done      = 1'b0;
		timed_out = 1'b0;
		void'($urandom(SEED));
		gen_program();
		reset_state();
		repeat (RESET_CYCLES) @(posedge clk);
		rst      <= 1'b1;
		checking = 1'b1;
		wait (done || timed_out);
		if (timed_out) begin
			other_errs++;
			$display("program did not reach ebreak");
		end
		$display("errors: wb %0d, word %0d, flag %0d, other %0d",
			wb_errs, word_errs, flag_errs, other_errs);
		if ((wb_errs + word_errs + flag_errs + other_errs) == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

/* rv_core.f */
logic/rv_pkg.sv
logic/pc_counter.sv
logic/register_file.sv
logic/decoder.sv
logic/execute.sv
logic/core_top.sv
+incdir+testbench
testbench/core_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -j 0
LINTFLAGS = --lint-only --timing --timescale 1ns/1ps
TOP       = core_tb
FILELIST  = rv_core.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
